//--- dev_table.sv
// Device-table slave with read-only discovery words and a reset-request register
module dev_table import soc_pkg::*; (
	input  logic              clk24mhz,
	input  logic              bus_rst_i,
	input  pi1_op_e           op_i,
	input  logic [OFS_W-1:0]  ofs_i,
	input  logic [DATA_W-1:0] wdata_i,
	output logic [DATA_W-1:0] rdata_o,
	output rst_req_e          rst_req_o
);

	logic [OFS_W-1:0]  entry;
	slave_e            entry_slv;
	logic [DATA_W-1:0] word_val;
	logic              is_read;

	// Words from 2 upward come in id and map-size pairs, one pair per slave
	assign entry     = ofs_i - OFS_W'(2);
	assign entry_slv = slave_e'(entry[2:1]);

	always_comb begin
		if (ofs_i == OFS_W'(0)) begin
			word_val = DATA_W'(SOC_ID);
		end else if (ofs_i == OFS_W'(1)) begin
			word_val = DATA_W'(SLAVE_CNT);
		end else if (ofs_i < OFS_W'(2 + 2 * SLAVE_CNT)) begin
			word_val = entry[0] ? slv_mapsz(entry_slv) : slv_id(entry_slv);
		end else begin
			word_val = '0;
		end
	end

	// Swap is treated as a plain read here
	assign is_read = (op_i == OP_RD) || (op_i == OP_RW);

	always_ff @(posedge clk24mhz) begin
		if (is_read) begin
			rdata_o <= word_val;
		end
	end

	// A write to word 0 becomes a single-cycle request
	always_ff @(posedge clk24mhz) begin
		if (bus_rst_i) begin
			rst_req_o <= REQ_NONE;
		end else if (op_i == OP_WR && ofs_i == OFS_W'(0)) begin
			rst_req_o <= rst_req_e'(wdata_i[1:0]);
		end else begin
			rst_req_o <= REQ_NONE;
		end
	end

endmodule

//--- irq_ctrl.sv
// Interrupt controller slave with pending latches, an enable mask and a claim register
module irq_ctrl import soc_pkg::*; (
	input  logic                 clk24mhz,
	input  logic                 bus_rst_i,
	input  pi1_op_e              op_i,
	input  logic [OFS_W-1:0]     ofs_i,
	input  logic [DATA_W-1:0]    wdata_i,
	input  logic [IRQ_SRC_N-1:0] irq_src_i,
	output logic [DATA_W-1:0]    rdata_o,
	output logic [IRQ_SRC_N-1:0] irq_src_rdy_o,
	output logic                 irq_o
);

	logic [IRQ_SRC_N-1:0] pending;
	logic [IRQ_SRC_N-1:0] enable;
	logic [IRQ_SRC_N-1:0] active;
	logic [IRQ_SRC_N-1:0] claim_onehot;
	logic [IRQ_SRC_N-1:0] claim_clr;
	logic [DATA_W-1:0]    claim_word;
	logic                 claim_hit;
	logic                 is_read;
	logic                 claim_rd;
	logic                 mask_wr;

	assign active = pending & enable;

	// Scan downward so the lowest active source wins
	always_comb begin
		claim_hit    = 1'b0;
		claim_word   = '0;
		claim_onehot = '0;
		for (int i = IRQ_SRC_N - 1; i >= 0; i--) begin
			if (active[i]) begin
				claim_hit    = 1'b1;
				claim_word   = DATA_W'(i);
				claim_onehot = IRQ_SRC_N'(1) << i;
			end
		end
	end

	assign is_read  = (op_i == OP_RD) || (op_i == OP_RW);
	assign claim_rd = is_read && (ofs_i == OFS_W'(0));
	assign mask_wr  = (op_i == OP_WR) && (ofs_i == OFS_W'(1));

	// Claiming clears only the source it reports
	assign claim_clr = claim_rd ? claim_onehot : '0;

	always_ff @(posedge clk24mhz) begin
		if (bus_rst_i) begin
			pending <= '0;
			enable  <= '1;
		end else begin
			// A new strobe takes priority over a same-cycle clear
			pending <= (pending & ~claim_clr) | irq_src_i;
			if (mask_wr) begin
				enable <= wdata_i[IRQ_SRC_N-1:0];
			end
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (is_read) begin
			if (ofs_i == OFS_W'(0)) begin
				rdata_o <= claim_hit ? claim_word : IRQ_NONE;
			end else if (ofs_i == OFS_W'(1)) begin
				rdata_o <= DATA_W'(enable);
			end else begin
				rdata_o <= '0;
			end
		end
	end

	// Sources see rdy drop once their strobe is latched
	assign irq_src_rdy_o = ~pending;
	assign irq_o         = |active;

endmodule

//--- pi1_router.sv
// Address decoder, per-slave opcode steering, invalid-device slave and read-data return mux
module pi1_router import soc_pkg::*; (
	input  logic              clk24mhz,
	input  logic              bus_rst_i,

	// Master side
	input  pi1_op_e           pi1_op_i,
	input  logic [ADDR_W-1:0] pi1_addr_i,
	input  logic [DATA_W-1:0] pi1_data_i,
	input  logic [SEL_W-1:0]  pi1_sel_i,
	output logic [DATA_W-1:0] pi1_data_o,
	output logic              pi1_rdy_o,

	// Slave side
	input  logic [DATA_W-1:0] devtbl_data_i,
	input  logic [DATA_W-1:0] irq_data_i,
	input  logic [DATA_W-1:0] ram_data_i,
	output pi1_op_e           devtbl_op_o,
	output pi1_op_e           irq_op_o,
	output pi1_op_e           ram_op_o,
	output logic [OFS_W-1:0]  ofs_o,
	output logic [DATA_W-1:0] wdata_o,
	output logic [SEL_W-1:0]  sel_o
);

	logic [DATA_W-1:0] byte_addr;
	slave_e            slv;
	slave_e            ret_slv;
	logic              is_read;

	assign byte_addr = {pi1_addr_i, 2'b00};

	// Anything outside the mapped slaves lands on the invalid device
	always_comb begin
		slave_e cand;
		slv = SLV_INVALID;
		for (int i = 0; i < SLAVE_CNT - 1; i++) begin
			cand = slave_e'(i);
			if (byte_addr >= slv_base(cand) &&
			    byte_addr < slv_base(cand) + slv_mapsz(cand)) begin
				slv = cand;
			end
		end
	end

	// The bus only stalls during bus reset
	assign pi1_rdy_o = !bus_rst_i;

	// Only the decoded slave sees the opcode, and only when accepted
	assign devtbl_op_o = (pi1_rdy_o && slv == SLV_DEVTBL)  ? pi1_op_i : OP_NOOP;
	assign irq_op_o    = (pi1_rdy_o && slv == SLV_IRQCTRL) ? pi1_op_i : OP_NOOP;
	assign ram_op_o    = (pi1_rdy_o && slv == SLV_RAM)     ? pi1_op_i : OP_NOOP;

	// Bases are map-size aligned so the low word bits are the offset
	assign ofs_o   = pi1_addr_i[OFS_W-1:0];
	assign wdata_o = pi1_data_i;
	assign sel_o   = pi1_sel_i;

	assign is_read = (pi1_op_i == OP_RD) || (pi1_op_i == OP_RW);

	// Remember who answers the read returning next cycle
	always_ff @(posedge clk24mhz) begin
		if (bus_rst_i) begin
			ret_slv <= SLV_INVALID;
		end else if (is_read) begin
			ret_slv <= slv;
		end
	end

	// Invalid device reads as zero and drops its writes
	always_comb begin
		case (ret_slv)
			SLV_DEVTBL:  pi1_data_o = devtbl_data_i;
			SLV_IRQCTRL: pi1_data_o = irq_data_i;
			SLV_RAM:     pi1_data_o = ram_data_i;
			default:     pi1_data_o = '0;
		endcase
	end

endmodule

//--- reset_seq.sv
// Bus reset stretch counter, software reset request decode and power-off latch
module reset_seq import soc_pkg::*; (
	input  logic     clk24mhz,
	input  logic     rst_p,
	input  rst_req_e rst_req_i,
	output logic     bus_rst_o,
	output logic     pwr_off_o
);

	logic [RST_CNT_W-1:0] rst_cnt;
	logic                 pwr_off;
	logic                 restart;
	logic                 power_down;

	// Cold and warm requests both restart the stretch
	always_comb begin
		restart    = 1'b0;
		power_down = 1'b0;
		case (rst_req_i)
			REQ_WARM,
			REQ_COLD:     restart = 1'b1;
			REQ_POWEROFF: power_down = 1'b1;
			default:      ;
		endcase
	end

	// Counter holds its full value while rst_p is high
	always_ff @(posedge clk24mhz) begin
		if (rst_p || restart) begin
			rst_cnt <= RST_CNT_W'(RST_CNT_CYCLES);
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
	end

	// Only the external reset leaves the power-off state
	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			pwr_off <= 1'b0;
		end else if (power_down) begin
			pwr_off <= 1'b1;
		end
	end

	assign bus_rst_o = (rst_cnt != '0) || pwr_off;
	assign pwr_off_o = pwr_off;

endmodule

//--- scratch_ram.sv
// Byte-selectable word RAM slave with read, write and swap
module scratch_ram import soc_pkg::*; (
	input  logic              clk24mhz,
	input  pi1_op_e           op_i,
	input  logic [OFS_W-1:0]  ofs_i,
	input  logic [DATA_W-1:0] wdata_i,
	input  logic [SEL_W-1:0]  sel_i,
	output logic [DATA_W-1:0] rdata_o
);

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic              do_read;
	logic              do_write;

	// Swap reads the old word and writes the new one in the same cycle
	assign do_read  = (op_i == OP_RD) || (op_i == OP_RW);
	assign do_write = (op_i == OP_WR) || (op_i == OP_RW);

	always_ff @(posedge clk24mhz) begin
		if (do_read) begin
			rdata_o <= mem[ofs_i];
		end
	end

	// Byte lanes under sel_i only
	always_ff @(posedge clk24mhz) begin
		if (do_write) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (sel_i[b]) begin
					mem[ofs_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
				end
			end
		end
	end

endmodule

//--- soc_pkg.sv
// Bus widths, opcode, slave and reset-request enums, address map, device ids and reset length
package soc_pkg;

	// Peripheral bus geometry
	localparam int unsigned DATA_W = 32;
	localparam int unsigned SEL_W  = DATA_W / 8;
	localparam int unsigned ADDR_W = 30;

	// Bus opcodes as encoded on the PI1 bus
	typedef enum logic [1:0] {
		OP_NOOP = 2'b00,
		OP_WR   = 2'b01,
		OP_RD   = 2'b10,
		OP_RW   = 2'b11
	} pi1_op_e;

	// Slave order also fixes the address map order
	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_IRQCTRL = 2'd1,
		SLV_RAM     = 2'd2,
		SLV_INVALID = 2'd3
	} slave_e;

	localparam int unsigned SLAVE_CNT = 4;

	// Map sizes in bytes
	localparam int unsigned DEVTBL_MAPSZ  = 256;
	localparam int unsigned IRQCTRL_MAPSZ = 256;
	localparam int unsigned RAM_MAPSZ     = 256;
	localparam int unsigned INVALID_MAPSZ = 4096;

	// Slaves are packed from address zero and the rest is invalid
	localparam int unsigned DEVTBL_BASE  = 0;
	localparam int unsigned IRQCTRL_BASE = DEVTBL_BASE + DEVTBL_MAPSZ;
	localparam int unsigned RAM_BASE     = IRQCTRL_BASE + IRQCTRL_MAPSZ;

	// Device ids reported by the device table
	localparam int unsigned DEVTBL_ID  = 7;
	localparam int unsigned IRQCTRL_ID = 3;
	localparam int unsigned RAM_ID     = 1;
	localparam int unsigned INVALID_ID = 0;
	localparam int unsigned SOC_ID     = 5;

	localparam int unsigned RAM_WORDS = 64;
	localparam int unsigned OFS_W     = 6;

	localparam int unsigned IRQ_SRC_N = 2;
	localparam logic [DATA_W-1:0] IRQ_NONE = '1;

	localparam int unsigned RST_CNT_CYCLES = 16;
	localparam int unsigned RST_CNT_W      = 5;

	// Codes written to device-table word 0
	typedef enum logic [1:0] {
		REQ_NONE     = 2'd0,
		REQ_POWEROFF = 2'd1,
		REQ_WARM     = 2'd2,
		REQ_COLD     = 2'd3
	} rst_req_e;

	function automatic logic [DATA_W-1:0] slv_base(slave_e s);
		case (s)
			SLV_DEVTBL:  return DATA_W'(DEVTBL_BASE);
			SLV_IRQCTRL: return DATA_W'(IRQCTRL_BASE);
			SLV_RAM:     return DATA_W'(RAM_BASE);
			default:     return DATA_W'(RAM_BASE + RAM_MAPSZ);
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] slv_mapsz(slave_e s);
		case (s)
			SLV_DEVTBL:  return DATA_W'(DEVTBL_MAPSZ);
			SLV_IRQCTRL: return DATA_W'(IRQCTRL_MAPSZ);
			SLV_RAM:     return DATA_W'(RAM_MAPSZ);
			default:     return DATA_W'(INVALID_MAPSZ);
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] slv_id(slave_e s);
		case (s)
			SLV_DEVTBL:  return DATA_W'(DEVTBL_ID);
			SLV_IRQCTRL: return DATA_W'(IRQCTRL_ID);
			SLV_RAM:     return DATA_W'(RAM_ID);
			default:     return DATA_W'(INVALID_ID);
		endcase
	endfunction

endpackage

//--- soc_top.f
soc_pkg.sv
reset_seq.sv
pi1_router.sv
dev_table.sv
irq_ctrl.sv
scratch_ram.sv
soc_top.sv
soc_top_tb.sv

//--- soc_top.sv
// Top level connecting the reset sequencer, the bus router and the three slaves
module soc_top import soc_pkg::*; (
	input  logic                 clk24mhz,
	input  logic                 rst_p,

	// Peripheral bus master port
	input  pi1_op_e              pi1_op_i,
	input  logic [ADDR_W-1:0]    pi1_addr_i,
	input  logic [DATA_W-1:0]    pi1_data_i,
	input  logic [SEL_W-1:0]     pi1_sel_i,
	output logic [DATA_W-1:0]    pi1_data_o,
	output logic                 pi1_rdy_o,

	// Interrupt sources and destination
	input  logic [IRQ_SRC_N-1:0] irq_src_i,
	output logic [IRQ_SRC_N-1:0] irq_src_rdy_o,
	output logic                 irq_o,

	output logic                 bus_rst_o,
	output logic                 pwr_off_o
);

	pi1_op_e           devtbl_op;
	pi1_op_e           irq_op;
	pi1_op_e           ram_op;
	logic [OFS_W-1:0]  slv_ofs;
	logic [DATA_W-1:0] slv_wdata;
	logic [SEL_W-1:0]  slv_sel;
	logic [DATA_W-1:0] devtbl_data;
	logic [DATA_W-1:0] irq_data;
	logic [DATA_W-1:0] ram_data;
	rst_req_e          rst_req;

	// bus_rst_o also fans out as the internal bus reset
	reset_seq u_reset_seq (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.rst_req_i (rst_req),
		.bus_rst_o (bus_rst_o),
		.pwr_off_o (pwr_off_o)
	);

	pi1_router u_router (
		.clk24mhz      (clk24mhz),
		.bus_rst_i     (bus_rst_o),
		.pi1_op_i      (pi1_op_i),
		.pi1_addr_i    (pi1_addr_i),
		.pi1_data_i    (pi1_data_i),
		.pi1_sel_i     (pi1_sel_i),
		.pi1_data_o    (pi1_data_o),
		.pi1_rdy_o     (pi1_rdy_o),
		.devtbl_data_i (devtbl_data),
		.irq_data_i    (irq_data),
		.ram_data_i    (ram_data),
		.devtbl_op_o   (devtbl_op),
		.irq_op_o      (irq_op),
		.ram_op_o      (ram_op),
		.ofs_o         (slv_ofs),
		.wdata_o       (slv_wdata),
		.sel_o         (slv_sel)
	);

	dev_table u_dev_table (
		.clk24mhz  (clk24mhz),
		.bus_rst_i (bus_rst_o),
		.op_i      (devtbl_op),
		.ofs_i     (slv_ofs),
		.wdata_i   (slv_wdata),
		.rdata_o   (devtbl_data),
		.rst_req_o (rst_req)
	);

	irq_ctrl u_irq_ctrl (
		.clk24mhz      (clk24mhz),
		.bus_rst_i     (bus_rst_o),
		.op_i          (irq_op),
		.ofs_i         (slv_ofs),
		.wdata_i       (slv_wdata),
		.irq_src_i     (irq_src_i),
		.rdata_o       (irq_data),
		.irq_src_rdy_o (irq_src_rdy_o),
		.irq_o         (irq_o)
	);

	// RAM keeps its contents across bus reset
	scratch_ram u_scratch_ram (
		.clk24mhz (clk24mhz),
		.op_i     (ram_op),
		.ofs_i    (slv_ofs),
		.wdata_i  (slv_wdata),
		.sel_i    (slv_sel),
		.rdata_o  (ram_data)
	);

endmodule

//--- soc_top_tb.sv
// Table-driven testbench for soc_top with clock, reset, watchdog, LCG and check task
module soc_top_tb import soc_pkg::*; ();

	logic                 clk24mhz;
	logic                 rst_p;
	pi1_op_e              pi1_op_i;
	logic [ADDR_W-1:0]    pi1_addr_i;
	logic [DATA_W-1:0]    pi1_data_i;
	logic [SEL_W-1:0]     pi1_sel_i;
	logic [DATA_W-1:0]    pi1_data_o;
	logic                 pi1_rdy_o;
	logic [IRQ_SRC_N-1:0] irq_src_i;
	logic [IRQ_SRC_N-1:0] irq_src_rdy_o;
	logic                 irq_o;
	logic                 bus_rst_o;
	logic                 pwr_off_o;

	// Stimulus table with one entry per bus request
	string             row_name[$];
	logic [1:0]        row_op[$];
	logic [ADDR_W-1:0] row_addr[$];
	logic [DATA_W-1:0] row_wdata[$];
	logic [SEL_W-1:0]  row_sel[$];
	logic [DATA_W-1:0] row_exp[$];
	bit                row_chk[$];
	int                grp_first[$];
	bit                table_ready;

	soc_top UUT (
		.clk24mhz      (clk24mhz),
		.rst_p         (rst_p),
		.pi1_op_i      (pi1_op_i),
		.pi1_addr_i    (pi1_addr_i),
		.pi1_data_i    (pi1_data_i),
		.pi1_sel_i     (pi1_sel_i),
		.pi1_data_o    (pi1_data_o),
		.pi1_rdy_o     (pi1_rdy_o),
		.irq_src_i     (irq_src_i),
		.irq_src_rdy_o (irq_src_rdy_o),
		.irq_o         (irq_o),
		.bus_rst_o     (bus_rst_o),
		.pwr_off_o     (pwr_off_o)
	);

	initial begin
		clk24mhz = 1'b0;
		forever #5 clk24mhz = ~clk24mhz;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [ADDR_W-1:0] word_addr(input int unsigned base, input int unsigned ofs);
		return ADDR_W'(base / 4 + ofs);
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("error: %s expected %h actual %h", name, exp, act);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	// Inputs change a little after the rising edge
	task automatic step();
		@(posedge clk24mhz);
		#1;
	endtask

	task automatic add_row(input string name, input pi1_op_e op, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [SEL_W-1:0] sel,
			input logic [DATA_W-1:0] exp, input bit chk);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(addr);
		row_wdata.push_back(wdata);
		row_sel.push_back(sel);
		row_exp.push_back(exp);
		row_chk.push_back(chk);
	endtask

	task automatic add_read(input string name, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] exp);
		add_row(name, OP_RD, addr, '0, '0, exp, 1'b1);
	endtask

	task automatic add_write(input string name, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [SEL_W-1:0] sel);
		add_row(name, OP_WR, addr, wdata, sel, '0, 1'b0);
	endtask

	task automatic start_group();
		grp_first.push_back(row_name.size());
	endtask

	task automatic build_table();
		int unsigned disc[10] = '{SOC_ID, SLAVE_CNT, DEVTBL_ID, DEVTBL_MAPSZ, IRQCTRL_ID,
			IRQCTRL_MAPSZ, RAM_ID, RAM_MAPSZ, INVALID_ID, INVALID_MAPSZ};
		logic [31:0] v[7];
		logic [31:0] seed;
		int unsigned inv_base;
		seed = 32'h106c;
		for (int i = 0; i < 7; i++) begin
			seed = lcg_next(seed);
			v[i] = seed;
		end
		inv_base = RAM_BASE + RAM_MAPSZ;
		// Group 0 discovery words
		start_group();
		for (int i = 0; i < 10; i++)
			add_read($sformatf("devtbl word %0d", i), word_addr(DEVTBL_BASE, i), disc[i]);
		// Group 1 RAM write, byte lanes and swap
		start_group();
		for (int i = 0; i < 4; i++)
			add_write($sformatf("ram wr %0d", i), word_addr(RAM_BASE, i), v[i], 4'hf);
		for (int i = 0; i < 4; i++)
			add_read($sformatf("ram rd %0d", i), word_addr(RAM_BASE, i), v[i]);
		add_write("ram wr 4", word_addr(RAM_BASE, 4), v[4], 4'hf);
		add_write("ram partial", word_addr(RAM_BASE, 4), 32'h11223344, 4'b0101);
		add_read("ram partial rd", word_addr(RAM_BASE, 4),
			{v[4][31:24], 8'h22, v[4][15:8], 8'h44});
		add_write("ram wr 5", word_addr(RAM_BASE, 5), v[5], 4'hf);
		add_row("ram swap", OP_RW, word_addr(RAM_BASE, 5), v[6], 4'hf, v[5], 1'b1);
		add_read("ram after swap", word_addr(RAM_BASE, 5), v[6]);
		// Group 2 invalid device whose write aliases RAM word 0 by offset
		start_group();
		add_read("invalid rd low", word_addr(inv_base, 0), '0);
		add_read("invalid rd top", '1, '0);
		add_write("invalid wr", word_addr(inv_base, 0), ~v[0], 4'hf);
		add_read("ram after invalid wr", word_addr(RAM_BASE, 0), v[0]);
		// Groups 3 to 7 interrupt claims and mask
		start_group();
		add_read("claim first", word_addr(IRQCTRL_BASE, 0), 32'd0);
		add_read("claim second", word_addr(IRQCTRL_BASE, 0), 32'd1);
		add_read("claim empty", word_addr(IRQCTRL_BASE, 0), IRQ_NONE);
		start_group();
		add_write("mask src 0", word_addr(IRQCTRL_BASE, 1), 32'd2, 4'hf);
		add_read("mask rd", word_addr(IRQCTRL_BASE, 1), 32'd2);
		start_group();
		add_read("claim masked", word_addr(IRQCTRL_BASE, 0), IRQ_NONE);
		start_group();
		// Source 1 stays masked so the reset value of the mask shows later
		add_write("unmask", word_addr(IRQCTRL_BASE, 1), 32'd1, 4'hf);
		start_group();
		add_read("claim unmasked", word_addr(IRQCTRL_BASE, 0), 32'd0);
		// Groups 8 to 11 software reset
		start_group();
		add_write("warm request", word_addr(DEVTBL_BASE, 0), REQ_WARM, 4'hf);
		start_group();
		for (int i = 0; i < 4; i++)
			add_read($sformatf("ram kept %0d", i), word_addr(RAM_BASE, i), v[i]);
		add_read("mask after reset", word_addr(IRQCTRL_BASE, 1), 32'd3);
		start_group();
		add_write("poweroff request", word_addr(DEVTBL_BASE, 0), REQ_POWEROFF, 4'hf);
		start_group();
		add_read("ram after poweroff", word_addr(RAM_BASE, 0), v[0]);
	endtask

	task automatic apply_row(input int i);
		while (!pi1_rdy_o)
			step();
		pi1_op_i   = pi1_op_e'(row_op[i]);
		pi1_addr_i = row_addr[i];
		pi1_data_i = row_wdata[i];
		pi1_sel_i  = row_sel[i];
		step();
		pi1_op_i = OP_NOOP;
		if (row_chk[i])
			check(row_name[i], row_exp[i], pi1_data_o);
	endtask

	task automatic run_group(input int g);
		int last;
		last = (g + 1 < grp_first.size()) ? grp_first[g+1] : row_name.size();
		for (int i = grp_first[g]; i < last; i++)
			apply_row(i);
	endtask

	task automatic apply_reset();
		rst_p = 1'b1;
		repeat (5) step();
		rst_p = 1'b0;
	endtask

	// Called at the first cycle with the counter full
	task automatic check_reset_stretch(input string name);
		for (int i = 0; i < RST_CNT_CYCLES; i++) begin
			check({name, " bus_rst_o"}, 1, bus_rst_o);
			check({name, " pi1_rdy_o"}, 0, pi1_rdy_o);
			check({name, " irq_o"}, 0, irq_o);
			check({name, " pwr_off_o"}, 0, pwr_off_o);
			check({name, " irq_src_rdy_o"}, 2'b11, irq_src_rdy_o);
			step();
		end
		check({name, " bus_rst_o end"}, 0, bus_rst_o);
		check({name, " pi1_rdy_o end"}, 1, pi1_rdy_o);
	endtask

	task automatic wait_bus_rst_rise(input string name);
		for (int i = 0; i < 2 && !bus_rst_o; i++)
			step();
		if (!bus_rst_o) begin
			$display("Bus reset did not rise within two cycles of the %s", name);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	// Source holds its strobe until rdy drops
	task automatic strobe_irq(input int src);
		irq_src_i[src] = 1'b1;
		step();
		while (irq_src_rdy_o[src])
			step();
		irq_src_i[src] = 1'b0;
	endtask

	initial begin
		int limit;
		wait (table_ready);
		limit = row_name.size() * 20 + 200;
		repeat (limit) @(posedge clk24mhz);
		$display("Run timed out after %0d cycles before all tests finished", limit);
		$display("ERRORS FOUND");
		$fatal(1);
	end

	initial begin
		rst_p      = 1'b1;
		pi1_op_i   = OP_NOOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i  = '0;
		irq_src_i  = '0;
		build_table();
		table_ready = 1'b1;

		apply_reset();
		check_reset_stretch("power-on reset");
		for (int g = 0; g < 3; g++)
			run_group(g);

		strobe_irq(1);
		check("irq after src 1", 1, irq_o);
		strobe_irq(0);
		check("irq after src 0", 1, irq_o);
		check("src rdy both pending", 2'b00, irq_src_rdy_o);
		run_group(3);
		check("irq after claims", 0, irq_o);
		check("src rdy after claims", 2'b11, irq_src_rdy_o);

		run_group(4);
		strobe_irq(0);
		check("masked irq", 0, irq_o);
		step();
		check("masked irq later", 0, irq_o);
		check("masked src pending", 2'b10, irq_src_rdy_o);
		run_group(5);
		run_group(6);
		check("irq after unmask", 1, irq_o);
		run_group(7);
		check("irq after last claim", 0, irq_o);

		run_group(8);
		wait_bus_rst_rise("warm request");
		check_reset_stretch("warm reset");
		run_group(9);

		run_group(10);
		wait_bus_rst_rise("poweroff request");
		repeat (2 * RST_CNT_CYCLES) begin
			check("poweroff pwr_off_o", 1, pwr_off_o);
			check("poweroff bus_rst_o", 1, bus_rst_o);
			check("poweroff pi1_rdy_o", 0, pi1_rdy_o);
			step();
		end
		apply_reset();
		check_reset_stretch("reset after poweroff");
		run_group(11);

		$display("NO ERRORS");
		$finish;
	end

endmodule
